// ==== logic/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [11:0] imm12_t;   // raw I or S field whose I form also carries the CSR index
    typedef logic [6:0]  opcode_t;

    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_system = 7'b1110011;

    // an all zero record with one bit per supported instruction marks an illegal word
    typedef struct packed {
        logic lui;
        logic auipc;
        logic jal;
        logic jalr;
        logic beq, bne, blt, bge, bltu, bgeu;
        logic lb, lh, lw, lbu, lhu;
        logic sb, sh, sw;
        logic addi, slti, sltiu, xori, ori, andi;
        logic slli, srli, srai;
        logic add, sub, sll, slt, sltu;
        logic xor_op, srl, sra, or_op, and_op;   // keyword clash for xor, or, and
        logic csrrw, csrrs, csrrc;
        logic csrrwi, csrrsi, csrrci;
    } inst_t;

endpackage

// ==== logic/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pkg::word_t  instr,
    output rv_pkg::inst_t  inst,
    output rv_pkg::word_t  imm,
    output rv_pkg::shamt_t zimm
);

    rv_pkg::opcode_t opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    rv_pkg::imm12_t  i_field;
    rv_pkg::imm12_t  s_field;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign i_field = instr[31:20];
    assign s_field = {instr[31:25], instr[11:7]};
    assign zimm    = instr[19:15];   // rs1 field doubles as the 5 bit CSR immediate

    always_comb begin
        inst = '0;
        case (opcode)
            rv_pkg::op_lui:   inst.lui   = 1'b1;
            rv_pkg::op_auipc: inst.auipc = 1'b1;
            rv_pkg::op_jal:   inst.jal   = 1'b1;
            rv_pkg::op_jalr:  inst.jalr  = (funct3 == 3'b000);
            rv_pkg::op_branch: begin
                inst.beq  = (funct3 == 3'b000);
                inst.bne  = (funct3 == 3'b001);
                inst.blt  = (funct3 == 3'b100);
                inst.bge  = (funct3 == 3'b101);
                inst.bltu = (funct3 == 3'b110);
                inst.bgeu = (funct3 == 3'b111);
            end
            rv_pkg::op_load: begin
                inst.lb  = (funct3 == 3'b000);
                inst.lh  = (funct3 == 3'b001);
                inst.lw  = (funct3 == 3'b010);
                inst.lbu = (funct3 == 3'b100);
                inst.lhu = (funct3 == 3'b101);
            end
            rv_pkg::op_store: begin
                inst.sb = (funct3 == 3'b000);
                inst.sh = (funct3 == 3'b001);
                inst.sw = (funct3 == 3'b010);
            end
            rv_pkg::op_imm: begin
                inst.addi  = (funct3 == 3'b000);
                inst.slti  = (funct3 == 3'b010);
                inst.sltiu = (funct3 == 3'b011);
                inst.xori  = (funct3 == 3'b100);
                inst.ori   = (funct3 == 3'b110);
                inst.andi  = (funct3 == 3'b111);
                inst.slli  = (funct3 == 3'b001) && (funct7 == 7'b0000000);
                inst.srli  = (funct3 == 3'b101) && (funct7 == 7'b0000000);
                inst.srai  = (funct3 == 3'b101) && (funct7 == 7'b0100000);
            end
            rv_pkg::op_reg: begin
                if (funct7 == 7'b0000000) begin
                    inst.add    = (funct3 == 3'b000);
                    inst.sll    = (funct3 == 3'b001);
                    inst.slt    = (funct3 == 3'b010);
                    inst.sltu   = (funct3 == 3'b011);
                    inst.xor_op = (funct3 == 3'b100);
                    inst.srl    = (funct3 == 3'b101);
                    inst.or_op  = (funct3 == 3'b110);
                    inst.and_op = (funct3 == 3'b111);
                end else if (funct7 == 7'b0100000) begin
                    inst.sub = (funct3 == 3'b000);
                    inst.sra = (funct3 == 3'b101);
                end
            end
            rv_pkg::op_system: begin   // funct3 of zero holds ecall and ebreak, which stay illegal
                inst.csrrw  = (funct3 == 3'b001);
                inst.csrrs  = (funct3 == 3'b010);
                inst.csrrc  = (funct3 == 3'b011);
                inst.csrrwi = (funct3 == 3'b101);
                inst.csrrsi = (funct3 == 3'b110);
                inst.csrrci = (funct3 == 3'b111);
            end
            default: inst = '0;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_pkg::op_jalr, rv_pkg::op_load, rv_pkg::op_imm, rv_pkg::op_system:
                imm = {{20{i_field[11]}}, i_field};
            rv_pkg::op_store:
                imm = {{20{s_field[11]}}, s_field};
            rv_pkg::op_branch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            rv_pkg::op_lui, rv_pkg::op_auipc:
                imm = {instr[31:12], 12'b0};
            rv_pkg::op_jal:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// ==== logic/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu #(
    parameter int link_offset = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  rv_pkg::inst_t  inst,
    input  rv_pkg::word_t  rs1,
    input  rv_pkg::word_t  rs2,
    input  rv_pkg::word_t  pc,
    input  rv_pkg::word_t  csr,
    input  rv_pkg::word_t  imm,
    input  rv_pkg::shamt_t zimm,
    output rv_pkg::word_t  rslt
);

    localparam rv_pkg::word_t step = rv_pkg::word_t'(link_offset);

    logic           jump;
    logic           branch;
    logic           mem_op;
    logic           csr_imm;
    logic           csr_reg;
    logic           imm_form;
    logic           lt;
    logic           ltu;
    logic           cmp;
    rv_pkg::word_t  a;
    rv_pkg::word_t  b;
    rv_pkg::shamt_t shamt;
    rv_pkg::word_t  rslt_d;

    assign jump     = inst.jal | inst.jalr;
    assign branch   = inst.beq | inst.bne | inst.blt | inst.bge | inst.bltu | inst.bgeu;
    assign mem_op   = inst.lb | inst.lh | inst.lw | inst.lbu | inst.lhu |
                      inst.sb | inst.sh | inst.sw;
    assign csr_imm  = inst.csrrwi | inst.csrrsi | inst.csrrci;
    assign csr_reg  = inst.csrrw | inst.csrrs | inst.csrrc;
    assign imm_form = inst.lui | inst.auipc | mem_op | inst.addi | inst.slti | inst.sltiu |
                      inst.xori | inst.ori | inst.andi | inst.slli | inst.srli | inst.srai;

    always_comb begin
        if (inst.auipc | jump) begin
            a = pc;
        end else if (csr_imm) begin
            a = {27'b0, zimm};
        end else begin
            a = rs1;
        end

        if (jump) begin
            b = step;
        end else if (imm_form) begin
            b = imm;
        end else if (csr_imm | csr_reg) begin
            b = csr;
        end else begin
            b = rs2;
        end
    end

    assign shamt = b[4:0];   // only the low five bits of rs2 or the immediate count
    assign lt    = $signed(a) < $signed(b);
    assign ltu   = a < b;
    assign cmp   = (inst.beq & (a == b)) | (inst.bne & (a != b)) |
                   (inst.blt & lt) | (inst.bge & ~lt) |
                   (inst.bltu & ltu) | (inst.bgeu & ~ltu);

    always_comb begin
        if (branch) begin
            rslt_d = {31'b0, cmp};   // bit 0 carries the branch decision
        end else if (inst.slt | inst.slti) begin
            rslt_d = {31'b0, lt};
        end else if (inst.sltu | inst.sltiu) begin
            rslt_d = {31'b0, ltu};
        end else if (inst.lui) begin
            rslt_d = b;
        end else if (inst.sub) begin
            rslt_d = a - b;
        end else if (inst.auipc | jump | mem_op | inst.addi | inst.add) begin
            rslt_d = a + b;
        end else if (inst.sll | inst.slli) begin
            rslt_d = a << shamt;
        end else if (inst.srl | inst.srli) begin
            rslt_d = a >> shamt;
        end else if (inst.sra | inst.srai) begin
            rslt_d = $signed(a) >>> shamt;
        end else if (inst.xor_op | inst.xori) begin
            rslt_d = a ^ b;
        end else if (inst.or_op | inst.ori | inst.csrrs | inst.csrrsi) begin
            rslt_d = a | b;
        end else if (inst.and_op | inst.andi) begin
            rslt_d = a & b;
        end else if (inst.csrrw | inst.csrrwi) begin
            rslt_d = a;
        end else if (inst.csrrc | inst.csrrci) begin
            rslt_d = ~a & b;   // clear the bits named by the source
        end else begin
            rslt_d = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rslt <= '0;
        end else begin
            rslt <= rslt_d;
        end
    end

endmodule

// ==== logic/rv_flow_unit.sv ====
`timescale 1ns/1ps

module rv_flow_unit #(
    parameter int link_offset = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  rv_pkg::inst_t inst,
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t rs1,
    input  rv_pkg::word_t imm,
    input  rv_pkg::word_t csr,
    output rv_pkg::word_t target,
    output rv_pkg::word_t seq_pc,
    output rv_pkg::word_t old_csr,
    output logic          is_branch,
    output logic          is_jump,
    output logic          is_load,
    output logic          is_store,
    output logic          is_csr,
    output logic          writes_rd,
    output logic          illegal,
    output logic          valid_q
);

    logic          branch_d;
    logic          store_d;
    logic          illegal_d;
    rv_pkg::word_t jalr_sum;

    assign branch_d  = inst.beq | inst.bne | inst.blt | inst.bge | inst.bltu | inst.bgeu;
    assign store_d   = inst.sb | inst.sh | inst.sw;
    assign illegal_d = (inst == '0);
    assign jalr_sum  = rs1 + imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            target    <= '0;
            seq_pc    <= '0;
            old_csr   <= '0;
            is_branch <= 1'b0;
            is_jump   <= 1'b0;
            is_load   <= 1'b0;
            is_store  <= 1'b0;
            is_csr    <= 1'b0;
            writes_rd <= 1'b0;
            illegal   <= 1'b0;
            valid_q   <= 1'b0;
        end else begin
            target    <= inst.jalr ? {jalr_sum[31:1], 1'b0} : pc + imm;   // jalr drops bit 0
            seq_pc    <= pc + rv_pkg::word_t'(link_offset);
            old_csr   <= csr;
            is_branch <= branch_d;
            is_jump   <= inst.jal | inst.jalr;
            is_load   <= inst.lb | inst.lh | inst.lw | inst.lbu | inst.lhu;
            is_store  <= store_d;
            is_csr    <= inst.csrrw | inst.csrrs | inst.csrrc |
                         inst.csrrwi | inst.csrrsi | inst.csrrci;
            writes_rd <= ~(branch_d | store_d | illegal_d);
            illegal   <= illegal_d;
            valid_q   <= in_valid;
        end
    end

endmodule

// ==== logic/rv_result_merge.sv ====
`timescale 1ns/1ps

module rv_result_merge (
    input  rv_pkg::word_t rslt,
    input  rv_pkg::word_t target,
    input  rv_pkg::word_t seq_pc,
    input  rv_pkg::word_t old_csr,
    input  logic          is_branch,
    input  logic          is_jump,
    input  logic          is_load,
    input  logic          is_store,
    input  logic          is_csr,
    input  logic          writes_rd,
    input  logic          illegal,
    input  logic          valid_q,
    output rv_pkg::word_t rd_data,
    output rv_pkg::word_t next_pc,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t csr_wdata,
    output logic          rd_we,
    output logic          mem_read,
    output logic          mem_write,
    output logic          csr_we,
    output logic          branch_taken,
    output logic          illegal_inst,
    output logic          out_valid
);

    logic taken;

    assign taken = is_jump | (is_branch & rslt[0]);   // alu leaves the compare in bit 0

    assign rd_data      = is_csr ? old_csr : rslt;   // csr forms return the value before the write
    assign rd_we        = writes_rd & valid_q;
    assign mem_addr     = rslt;
    assign mem_read     = is_load & valid_q;
    assign mem_write    = is_store & valid_q;
    assign csr_wdata    = rslt;
    assign csr_we       = is_csr & valid_q;
    assign branch_taken = taken & valid_q;
    assign next_pc      = taken ? target : seq_pc;
    assign illegal_inst = illegal & valid_q;
    assign out_valid    = valid_q;

endmodule

// ==== logic/rv_exec_top.sv ====
`timescale 1ns/1ps

module rv_exec_top #(
    parameter int link_offset = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  rv_pkg::word_t instr,
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t rs1,
    input  rv_pkg::word_t rs2,
    input  rv_pkg::word_t csr_rdata,
    output rv_pkg::word_t rd_data,
    output logic          rd_we,
    output rv_pkg::word_t mem_addr,
    output logic          mem_read,
    output logic          mem_write,
    output rv_pkg::word_t csr_wdata,
    output logic          csr_we,
    output logic          branch_taken,
    output rv_pkg::word_t next_pc,
    output logic          illegal_inst,
    output logic          out_valid
);

    rv_pkg::inst_t  inst;
    rv_pkg::word_t  imm;
    rv_pkg::shamt_t zimm;
    rv_pkg::word_t  rslt;
    rv_pkg::word_t  target;
    rv_pkg::word_t  seq_pc;
    rv_pkg::word_t  old_csr;
    logic           is_branch;
    logic           is_jump;
    logic           is_load;
    logic           is_store;
    logic           is_csr;
    logic           writes_rd;
    logic           illegal;
    logic           valid_q;

    rv_decoder u_decoder (
        .instr (instr),
        .inst  (inst),
        .imm   (imm),
        .zimm  (zimm)
    );

    rv_alu #(
        .link_offset (link_offset)
    ) u_alu (
        .clk   (clk),
        .rst_n (rst_n),
        .inst  (inst),
        .rs1   (rs1),
        .rs2   (rs2),
        .pc    (pc),
        .csr   (csr_rdata),
        .imm   (imm),
        .zimm  (zimm),
        .rslt  (rslt)
    );

    // runs beside the alu on the same edge
    rv_flow_unit #(
        .link_offset (link_offset)
    ) u_flow (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .inst      (inst),
        .pc        (pc),
        .rs1       (rs1),
        .imm       (imm),
        .csr       (csr_rdata),
        .target    (target),
        .seq_pc    (seq_pc),
        .old_csr   (old_csr),
        .is_branch (is_branch),
        .is_jump   (is_jump),
        .is_load   (is_load),
        .is_store  (is_store),
        .is_csr    (is_csr),
        .writes_rd (writes_rd),
        .illegal   (illegal),
        .valid_q   (valid_q)
    );

    rv_result_merge u_merge (
        .rslt         (rslt),
        .target       (target),
        .seq_pc       (seq_pc),
        .old_csr      (old_csr),
        .is_branch    (is_branch),
        .is_jump      (is_jump),
        .is_load      (is_load),
        .is_store     (is_store),
        .is_csr       (is_csr),
        .writes_rd    (writes_rd),
        .illegal      (illegal),
        .valid_q      (valid_q),
        .rd_data      (rd_data),
        .next_pc      (next_pc),
        .mem_addr     (mem_addr),
        .csr_wdata    (csr_wdata),
        .rd_we        (rd_we),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .csr_we       (csr_we),
        .branch_taken (branch_taken),
        .illegal_inst (illegal_inst),
        .out_valid    (out_valid)
    );

endmodule

// ==== sim/rv_exec_assert.sv ====
`timescale 1ns/1ps

module rv_exec_assert (
    input logic clk,
    input logic rst_n,
    input logic rd_we,
    input logic mem_read,
    input logic mem_write,
    input logic csr_we,
    input logic branch_taken,
    input logic illegal_inst,
    input logic out_valid
);

    int violations = 0;

    one_side_effect: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({mem_read, mem_write, csr_we}))
        else begin
            violations++;
            $error("more than one of mem_read, mem_write and csr_we is high");
        end

    // no strobe may leave the stage without a valid result
    strobes_need_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> !(rd_we || mem_read || mem_write || csr_we ||
                         branch_taken || illegal_inst))
        else begin
            violations++;
            $error("a strobe is high while out_valid is low");
        end

    no_write_when_illegal: assert property (@(posedge clk) disable iff (!rst_n)
        illegal_inst |-> !rd_we)
        else begin
            violations++;
            $error("rd_we is high for an illegal instruction");
        end

endmodule

bind rv_exec_top rv_exec_assert u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_we        (rd_we),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .csr_we       (csr_we),
    .branch_taken (branch_taken),
    .illegal_inst (illegal_inst),
    .out_valid    (out_valid)
);

// ==== sim/tb_rv_exec.sv ====
`timescale 1ns/1ps

module tb_rv_exec;

    localparam int n_instr      = 2000;
    localparam int reset_cycles = 8;
    localparam int idle_cycles  = 4;
    localparam int cycle_limit  = n_instr + idle_cycles + reset_cycles + 50;

    // f3 codes per group with entry 0 in the lowest octal digit
    localparam logic [17:0] branch_f3 = 18'o765410;
    localparam logic [14:0] load_f3   = 15'o54210;
    localparam logic [26:0] imm_f3    = 27'o551764320;   // addi .. andi, slli, srli, srai
    localparam logic [29:0] reg_f3    = 30'o7655432100;  // add, sub, sll .. sra, or, and
    localparam logic [17:0] csr_f3    = 18'o765321;

    logic          clk;
    logic          rst_n;
    logic          in_valid;
    rv_pkg::word_t instr;
    rv_pkg::word_t pc;
    rv_pkg::word_t rs1;
    rv_pkg::word_t rs2;
    rv_pkg::word_t csr_rdata;
    rv_pkg::word_t rd_data;
    rv_pkg::word_t mem_addr;
    rv_pkg::word_t csr_wdata;
    rv_pkg::word_t next_pc;
    logic          rd_we;
    logic          mem_read;
    logic          mem_write;
    logic          csr_we;
    logic          branch_taken;
    logic          illegal_inst;
    logic          out_valid;

    // expectations for the instruction that is in flight
    logic          exp_valid;
    logic          exp_rd_we;
    logic          exp_mem_read;
    logic          exp_mem_write;
    logic          exp_csr_we;
    logic          exp_taken;
    logic          exp_illegal;
    rv_pkg::word_t exp_rd_data;
    rv_pkg::word_t exp_addr;
    rv_pkg::word_t exp_csr_wdata;
    rv_pkg::word_t exp_next_pc;

    rv_pkg::word_t lfsr_state = 32'h5918;
    int            errors = 0;
    int            cycles = 0;

    rv_exec_top #(
        .link_offset (4)
    ) UUT (
        .clk (clk), .rst_n (rst_n), .in_valid (in_valid), .instr (instr), .pc (pc),
        .rs1 (rs1), .rs2 (rs2), .csr_rdata (csr_rdata), .rd_data (rd_data),
        .rd_we (rd_we), .mem_addr (mem_addr), .mem_read (mem_read),
        .mem_write (mem_write), .csr_wdata (csr_wdata), .csr_we (csr_we),
        .branch_taken (branch_taken), .next_pc (next_pc),
        .illegal_inst (illegal_inst), .out_valid (out_valid)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: the test did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic rv_pkg::word_t take_bits(input int n);
        rv_pkg::word_t bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    // random fields everywhere, then opcode, funct3 and funct7 of entry idx
    function automatic rv_pkg::word_t encode(input int idx, input rv_pkg::word_t r);
        rv_pkg::word_t w;
        w = r;
        if (idx == 0) begin
            w[6:0] = rv_pkg::op_lui;
        end else if (idx == 1) begin
            w[6:0] = rv_pkg::op_auipc;
        end else if (idx == 2) begin
            w[6:0] = rv_pkg::op_jal;
        end else if (idx == 3) begin
            w[6:0]   = rv_pkg::op_jalr;
            w[14:12] = 3'd0;
        end else if (idx < 10) begin
            w[6:0]   = rv_pkg::op_branch;
            w[14:12] = branch_f3[3*(idx-4) +: 3];
        end else if (idx < 15) begin
            w[6:0]   = rv_pkg::op_load;
            w[14:12] = load_f3[3*(idx-10) +: 3];
        end else if (idx < 18) begin
            w[6:0]   = rv_pkg::op_store;
            w[14:12] = 3'(idx - 15);
        end else if (idx < 27) begin
            w[6:0]   = rv_pkg::op_imm;
            w[14:12] = imm_f3[3*(idx-18) +: 3];
            if (idx >= 24) begin   // shifts carry funct7 in the immediate
                w[31:25] = (idx == 26) ? 7'h20 : 7'h00;
            end
        end else if (idx < 37) begin
            w[6:0]   = rv_pkg::op_reg;
            w[14:12] = reg_f3[3*(idx-27) +: 3];
            w[31:25] = (idx == 28 || idx == 34) ? 7'h20 : 7'h00;
        end else begin
            w[6:0]   = rv_pkg::op_system;
            w[14:12] = csr_f3[3*(idx-37) +: 3];
        end
        return w;
    endfunction

    task automatic drive_random(input logic idle);
        rv_pkg::word_t r;
        r = take_bits(32);
        if (take_bits(4) == 0) begin
            instr = r;   // raw word that mostly has an illegal opcode
        end else begin
            instr = encode(int'(take_bits(6) % 43), r);
        end
        pc        = take_bits(30) << 2;
        rs1       = take_bits(32);
        rs2       = (take_bits(2) == 0) ? rs1 : take_bits(32);
        csr_rdata = take_bits(32);
        in_valid  = !idle && (take_bits(2) != 0);
    endtask

    task automatic predict();
        rv_pkg::opcode_t op;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [4:0]      sh;
        rv_pkg::word_t   imm_i;
        rv_pkg::word_t   imm_s;
        rv_pkg::word_t   imm_b;
        rv_pkg::word_t   imm_u;
        rv_pkg::word_t   imm_j;
        rv_pkg::word_t   src;
        rv_pkg::word_t   res;
        rv_pkg::word_t   seq;
        rv_pkg::word_t   tgt;
        logic            legal;
        logic            wr;
        logic            ld;
        logic            st;
        logic            cs;
        logic            take;
        op    = instr[6:0];
        f3    = instr[14:12];
        f7    = instr[31:25];
        sh    = instr[24:20];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u = {instr[31:12], 12'b0};
        imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        seq   = pc + 32'd4;
        src   = '0;
        res   = '0;
        tgt   = '0;
        {legal, wr, ld, st, cs, take} = 6'b110000;
        case (op)
            rv_pkg::op_lui:   res = imm_u;
            rv_pkg::op_auipc: res = pc + imm_u;
            rv_pkg::op_jal: begin
                res  = seq;
                take = 1'b1;
                tgt  = pc + imm_j;
            end
            rv_pkg::op_jalr: begin
                legal = (f3 == 3'd0);
                res   = seq;
                take  = 1'b1;
                tgt   = (rs1 + imm_i) & ~32'd1;
            end
            rv_pkg::op_branch: begin
                wr  = 1'b0;
                tgt = pc + imm_b;
                case (f3)
                    3'd0:    take = (rs1 == rs2);
                    3'd1:    take = (rs1 != rs2);
                    3'd4:    take = ($signed(rs1) < $signed(rs2));
                    3'd5:    take = ($signed(rs1) >= $signed(rs2));
                    3'd6:    take = (rs1 < rs2);
                    3'd7:    take = (rs1 >= rs2);
                    default: legal = 1'b0;
                endcase
            end
            rv_pkg::op_load: begin
                ld    = 1'b1;
                res   = rs1 + imm_i;
                legal = (f3 != 3'd3) && (f3 != 3'd6) && (f3 != 3'd7);
            end
            rv_pkg::op_store: begin
                st    = 1'b1;
                wr    = 1'b0;
                res   = rs1 + imm_s;
                legal = (f3 < 3'd3);
            end
            rv_pkg::op_imm: begin
                case (f3)
                    3'd0: res = rs1 + imm_i;
                    3'd2: res = {31'b0, $signed(rs1) < $signed(imm_i)};
                    3'd3: res = {31'b0, rs1 < imm_i};
                    3'd4: res = rs1 ^ imm_i;
                    3'd6: res = rs1 | imm_i;
                    3'd7: res = rs1 & imm_i;
                    3'd1: begin
                        res   = rs1 << sh;
                        legal = (f7 == 7'h00);
                    end
                    default: begin
                        res   = f7[5] ? rv_pkg::word_t'($signed(rs1) >>> sh) : rs1 >> sh;
                        legal = (f7 == 7'h00) || (f7 == 7'h20);
                    end
                endcase
            end
            rv_pkg::op_reg: begin
                sh    = rs2[4:0];   // only the low five bits shift
                legal = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
                case (f3)
                    3'd0:    res = f7[5] ? rs1 - rs2 : rs1 + rs2;
                    3'd1:    res = rs1 << sh;
                    3'd2:    res = {31'b0, $signed(rs1) < $signed(rs2)};
                    3'd3:    res = {31'b0, rs1 < rs2};
                    3'd4:    res = rs1 ^ rs2;
                    3'd5:    res = f7[5] ? rv_pkg::word_t'($signed(rs1) >>> sh) : rs1 >> sh;
                    3'd6:    res = rs1 | rs2;
                    default: res = rs1 & rs2;
                endcase
            end
            rv_pkg::op_system: begin
                cs  = 1'b1;
                src = f3[2] ? {27'b0, instr[19:15]} : rs1;
                case (f3[1:0])
                    2'd1:    res = src;
                    2'd2:    res = csr_rdata | src;
                    2'd3:    res = csr_rdata & ~src;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            {wr, ld, st, cs, take} = 5'b0;
        end
        exp_valid     = in_valid;
        exp_rd_we     = in_valid & wr;
        exp_mem_read  = in_valid & ld;
        exp_mem_write = in_valid & st;
        exp_csr_we    = in_valid & cs;
        exp_taken     = in_valid & take;
        exp_illegal   = in_valid & ~legal;
        exp_rd_data   = cs ? csr_rdata : res;   // csr forms return the old value
        exp_addr      = res;
        exp_csr_wdata = res;
        exp_next_pc   = take ? tgt : seq;
    endtask

    task automatic compare_bit(input string name, input logic got, input logic want);
        assert (got === want) else begin
            errors++;
            $display("[ERROR] %0t %s: got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic compare_word(input string name, input rv_pkg::word_t got,
                                input rv_pkg::word_t want);
        assert (got === want) else begin
            errors++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_outputs();
        compare_bit("out_valid", out_valid, exp_valid);
        compare_bit("rd_we", rd_we, exp_rd_we);
        compare_bit("mem_read", mem_read, exp_mem_read);
        compare_bit("mem_write", mem_write, exp_mem_write);
        compare_bit("csr_we", csr_we, exp_csr_we);
        compare_bit("branch_taken", branch_taken, exp_taken);
        compare_bit("illegal_inst", illegal_inst, exp_illegal);
        if (exp_rd_we) begin
            compare_word("rd_data", rd_data, exp_rd_data);
        end
        if (exp_mem_read || exp_mem_write) begin
            compare_word("mem_addr", mem_addr, exp_addr);
        end
        if (exp_csr_we) begin
            compare_word("csr_wdata", csr_wdata, exp_csr_wdata);
        end
        if (exp_valid) begin
            compare_word("next_pc", next_pc, exp_next_pc);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        instr     = '0;
        pc        = '0;
        rs1       = '0;
        rs2       = '0;
        csr_rdata = '0;
        {exp_valid, exp_rd_we, exp_mem_read, exp_mem_write} = '0;
        {exp_csr_we, exp_taken, exp_illegal} = '0;
        {exp_rd_data, exp_addr, exp_csr_wdata, exp_next_pc} = '0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < idle_cycles + n_instr; i++) begin
            @(negedge clk);
            check_outputs();
            drive_random(i < idle_cycles);   // first cycles keep in_valid low
            predict();
        end
        @(negedge clk);
        check_outputs();
        $display("summary: %0d value errors, %0d assertion failures",
                 errors, UUT.u_assert.violations);
        if (errors == 0 && UUT.u_assert.violations == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_alu.sv
logic/rv_flow_unit.sv
logic/rv_result_merge.sv
logic/rv_exec_top.sv
sim/rv_exec_assert.sv
sim/tb_rv_exec.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_rv_exec -f compile.f
	./obj_dir/Vtb_rv_exec +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	grep -q "^All checks passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
